//--- rtl/axi_pkg.sv
// AXI4 burst, size and response encodings

`default_nettype none

package axi_pkg;

   // Channel field widths for the AXI4 master
   localparam int AXI_LEN_WIDTH  = 4;
   localparam int AXI_SIZE_WIDTH = 3;

   // Burst types
   typedef enum logic [1:0]
   {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_e;

   // Response codes on R and B
   typedef enum logic [1:0]
   {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // Beat size code, 2**3 bytes per beat
   localparam logic [AXI_SIZE_WIDTH-1:0] AXI_SIZE_BYTES_8 = 3'd3;

endpackage

`default_nettype wire

//--- rtl/dma_pkg.sv
// DMA packet and DRAM address types

`default_nettype none

package dma_pkg;

   // DRAM byte address and data path widths
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 64;

   // Address fields, row on top and byte offset at the bottom
   localparam int ROW_WIDTH    = 21;
   localparam int BANK_WIDTH   = 3;
   localparam int OFFSET_WIDTH = 8;

   typedef struct packed
   {
      logic [ROW_WIDTH-1:0]    row;
      logic [BANK_WIDTH-1:0]   bank;
      logic [OFFSET_WIDTH-1:0] offset;
   } dram_addr_fields_s;

   // Same word seen as a linear AXI address or as hash fields
   typedef union packed
   {
      logic [ADDR_WIDTH-1:0] flat;
      dram_addr_fields_s     fields;
   } dram_addr_u;

   // One block request from the cache
   typedef struct packed
   {
      logic       write_not_read;
      dram_addr_u addr;
   } dma_pkt_s;

endpackage

`default_nettype wire

//--- rtl/dma_addr_unhash.sv
// DRAM address unhash stage

`default_nettype none

module dma_addr_unhash
   import dma_pkg::*;
   (input  logic     clk_i
   , input  logic     arst_n_i

   , input  dma_pkt_s dma_pkt_i
   , input  logic     dma_pkt_v_i
   , output logic     dma_pkt_ready_o

   , output dma_pkt_s unhash_pkt_o
   , output logic     unhash_v_o
   , input  logic     unhash_ready_i
   );

   dram_addr_u hashed_addr;
   dram_addr_u linear_addr;
   dma_pkt_s   pkt_r;
   logic       v_r;
   logic       live_r;

   assign hashed_addr = dma_pkt_i.addr;

   // Hashed bank is true bank XOR low row bits, so the same XOR undoes it
   always_comb
   begin
      linear_addr = hashed_addr;
      linear_addr.fields.bank = hashed_addr.fields.bank
                              ^ hashed_addr.fields.row[BANK_WIDTH-1:0];
   end

   // Register can refill in the cycle its packet leaves
   assign dma_pkt_ready_o = live_r && (!v_r || unhash_ready_i);

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         v_r    <= 1'b0;
         live_r <= 1'b0;
      end
      else
      begin
         live_r <= 1'b1;
         if (dma_pkt_ready_o)
            v_r <= dma_pkt_v_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (dma_pkt_ready_o && dma_pkt_v_i)
      begin
         pkt_r.write_not_read <= dma_pkt_i.write_not_read;
         pkt_r.addr           <= linear_addr;
      end
   end

   assign unhash_pkt_o = pkt_r;
   assign unhash_v_o   = v_r;

   // Output held under back-pressure
   a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      unhash_v_o && !unhash_ready_i |=> unhash_v_o && $stable(unhash_pkt_o));

endmodule

`default_nettype wire

//--- rtl/dma_cmd_fifo.sv
// Command FIFO of unhashed DMA packets

`default_nettype none

module dma_cmd_fifo
   import dma_pkg::*;
   #(parameter int FIFO_DEPTH = 4)
   (input  logic     clk_i
   , input  logic     arst_n_i

   , input  dma_pkt_s data_i
   , input  logic     v_i
   , output logic     ready_o

   , output dma_pkt_s data_o
   , output logic     v_o
   , input  logic     yumi_i
   );

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)
   begin : g_bad_depth
      $error("FIFO_DEPTH must be a power of two of at least 2");
   end

   dma_pkt_s         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_r;
   logic [PTR_W-1:0] rd_ptr_r;
   logic [CNT_W-1:0] count_r;
   logic             wr_en;

   assign ready_o = (count_r != CNT_W'(FIFO_DEPTH));
   assign v_o     = (count_r != '0);
   assign data_o  = mem[rd_ptr_r];
   assign wr_en   = v_i && ready_o;

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (yumi_i)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         if (wr_en && !yumi_i)
            count_r <= count_r + 1'b1;
         else if (!wr_en && yumi_i)
            count_r <= count_r - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
         mem[wr_ptr_r] <= data_i;
   end

   a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      yumi_i |-> v_o);

   a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      count_r <= CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- rtl/axi_burst_master.sv
// DMA packet to AXI4 burst engine

`default_nettype none

module axi_burst_master
   import dma_pkg::*;
   import axi_pkg::*;
   #(parameter int BURST_LEN = 4)
   (input  logic                      clk_i
   , input  logic                      arst_n_i

   , input  dma_pkt_s                  cmd_pkt_i
   , input  logic                      cmd_v_i
   , output logic                      cmd_yumi_o

   , input  logic [DATA_WIDTH-1:0]     dma_data_i
   , input  logic                      dma_data_v_i
   , output logic                      dma_data_ready_o
   , output logic [DATA_WIDTH-1:0]     dma_data_o
   , output logic                      dma_data_v_o
   , input  logic                      dma_data_ready_i

   , output logic [ADDR_WIDTH-1:0]     m_axi_araddr_o
   , output logic [AXI_LEN_WIDTH-1:0]  m_axi_arlen_o
   , output logic [AXI_SIZE_WIDTH-1:0] m_axi_arsize_o
   , output logic [1:0]                m_axi_arburst_o
   , output logic                      m_axi_arvalid_o
   , input  logic                      m_axi_arready_i
   , input  logic [DATA_WIDTH-1:0]     m_axi_rdata_i
   , input  logic [1:0]                m_axi_rresp_i
   , input  logic                      m_axi_rlast_i
   , input  logic                      m_axi_rvalid_i
   , output logic                      m_axi_rready_o

   , output logic [ADDR_WIDTH-1:0]     m_axi_awaddr_o
   , output logic [AXI_LEN_WIDTH-1:0]  m_axi_awlen_o
   , output logic [AXI_SIZE_WIDTH-1:0] m_axi_awsize_o
   , output logic [1:0]                m_axi_awburst_o
   , output logic                      m_axi_awvalid_o
   , input  logic                      m_axi_awready_i
   , output logic [DATA_WIDTH-1:0]     m_axi_wdata_o
   , output logic [DATA_WIDTH/8-1:0]   m_axi_wstrb_o
   , output logic                      m_axi_wlast_o
   , output logic                      m_axi_wvalid_o
   , input  logic                      m_axi_wready_i
   , input  logic [1:0]                m_axi_bresp_i
   , input  logic                      m_axi_bvalid_i
   , output logic                      m_axi_bready_o
   );

   localparam int BEAT_W = $clog2(BURST_LEN);

   if (BURST_LEN < 2 || BURST_LEN > 16)
   begin : g_bad_len
      $error("BURST_LEN must be between 2 and 16");
   end

   typedef enum logic [2:0]
   {
      ST_IDLE,
      ST_RD_ADDR,
      ST_RD_DATA,
      ST_WR_ADDR,
      ST_WR_DATA,
      ST_WR_RESP
   } state_e;

   state_e                state_r;
   logic [ADDR_WIDTH-1:0] addr_r;
   logic [BEAT_W-1:0]     beat_r;
   logic                  last_beat;
   logic                  r_fire;
   logic                  w_fire;
   logic                  b_fire;

   assign last_beat  = (beat_r == BEAT_W'(BURST_LEN - 1));
   assign cmd_yumi_o = (state_r == ST_IDLE) && cmd_v_i;
   assign r_fire     = m_axi_rvalid_i && m_axi_rready_o;
   assign w_fire     = m_axi_wvalid_o && m_axi_wready_i;
   assign b_fire     = m_axi_bvalid_i && m_axi_bready_o;

   // One burst in flight, chosen by the head packet
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_r <= ST_IDLE;
         beat_r  <= '0;
      end
      else
      begin
         case (state_r)
            ST_IDLE:
            begin
               beat_r <= '0;
               if (cmd_yumi_o)
               begin
                  if (cmd_pkt_i.write_not_read)
                     state_r <= ST_WR_ADDR;
                  else
                     state_r <= ST_RD_ADDR;
               end
            end
            ST_RD_ADDR:
               if (m_axi_arready_i)
                  state_r <= ST_RD_DATA;
            ST_RD_DATA:
               if (r_fire)
               begin
                  beat_r <= beat_r + 1'b1;
                  if (m_axi_rlast_i)
                     state_r <= ST_IDLE;
               end
            ST_WR_ADDR:
               if (m_axi_awready_i)
                  state_r <= ST_WR_DATA;
            ST_WR_DATA:
               if (w_fire)
               begin
                  beat_r <= beat_r + 1'b1;
                  if (last_beat)
                     state_r <= ST_WR_RESP;
               end
            ST_WR_RESP:
               if (b_fire)
                  state_r <= ST_IDLE;
            default:
               state_r <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_yumi_o)
         addr_r <= cmd_pkt_i.addr.flat;
   end

   // Address channels
   assign m_axi_araddr_o  = addr_r;
   assign m_axi_arlen_o   = AXI_LEN_WIDTH'(BURST_LEN - 1);
   assign m_axi_arsize_o  = AXI_SIZE_BYTES_8;
   assign m_axi_arburst_o = INCR;
   assign m_axi_arvalid_o = (state_r == ST_RD_ADDR);

   assign m_axi_awaddr_o  = addr_r;
   assign m_axi_awlen_o   = AXI_LEN_WIDTH'(BURST_LEN - 1);
   assign m_axi_awsize_o  = AXI_SIZE_BYTES_8;
   assign m_axi_awburst_o = INCR;
   assign m_axi_awvalid_o = (state_r == ST_WR_ADDR);

   // R beats pass straight to the DMA fill port
   assign dma_data_o     = m_axi_rdata_i;
   assign dma_data_v_o   = (state_r == ST_RD_DATA) && m_axi_rvalid_i;
   assign m_axi_rready_o = (state_r == ST_RD_DATA) && dma_data_ready_i;

   // Evict data goes out as W beats, full blocks only
   assign m_axi_wdata_o    = dma_data_i;
   assign m_axi_wstrb_o    = '1;
   assign m_axi_wlast_o    = last_beat;
   assign m_axi_wvalid_o   = (state_r == ST_WR_DATA) && dma_data_v_i;
   assign dma_data_ready_o = (state_r == ST_WR_DATA) && m_axi_wready_i;

   assign m_axi_bready_o = (state_r == ST_WR_RESP);

   a_rlast_on_last_beat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      r_fire |-> (m_axi_rlast_i == last_beat));

   a_rresp_okay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      r_fire |-> (m_axi_rresp_i == OKAY));

   a_bresp_okay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      b_fire |-> (m_axi_bresp_i == OKAY));

endmodule

`default_nettype wire

//--- rtl/cache_dma_axi_top.sv
// Cache DMA to AXI4 memory bridge

`default_nettype none

module cache_dma_axi_top
   import dma_pkg::*;
   import axi_pkg::*;
   #(parameter int FIFO_DEPTH = 4
   , parameter int BURST_LEN  = 4
   )
   (input  logic                      clk_i
   , input  logic                      arst_n_i

   , input  dma_pkt_s                  dma_pkt_i
   , input  logic                      dma_pkt_v_i
   , output logic                      dma_pkt_ready_o

   , input  logic [DATA_WIDTH-1:0]     dma_data_i
   , input  logic                      dma_data_v_i
   , output logic                      dma_data_ready_o
   , output logic [DATA_WIDTH-1:0]     dma_data_o
   , output logic                      dma_data_v_o
   , input  logic                      dma_data_ready_i

   , output logic [ADDR_WIDTH-1:0]     m_axi_araddr_o
   , output logic [AXI_LEN_WIDTH-1:0]  m_axi_arlen_o
   , output logic [AXI_SIZE_WIDTH-1:0] m_axi_arsize_o
   , output logic [1:0]                m_axi_arburst_o
   , output logic                      m_axi_arvalid_o
   , input  logic                      m_axi_arready_i
   , input  logic [DATA_WIDTH-1:0]     m_axi_rdata_i
   , input  logic [1:0]                m_axi_rresp_i
   , input  logic                      m_axi_rlast_i
   , input  logic                      m_axi_rvalid_i
   , output logic                      m_axi_rready_o

   , output logic [ADDR_WIDTH-1:0]     m_axi_awaddr_o
   , output logic [AXI_LEN_WIDTH-1:0]  m_axi_awlen_o
   , output logic [AXI_SIZE_WIDTH-1:0] m_axi_awsize_o
   , output logic [1:0]                m_axi_awburst_o
   , output logic                      m_axi_awvalid_o
   , input  logic                      m_axi_awready_i
   , output logic [DATA_WIDTH-1:0]     m_axi_wdata_o
   , output logic [DATA_WIDTH/8-1:0]   m_axi_wstrb_o
   , output logic                      m_axi_wlast_o
   , output logic                      m_axi_wvalid_o
   , input  logic                      m_axi_wready_i
   , input  logic [1:0]                m_axi_bresp_i
   , input  logic                      m_axi_bvalid_i
   , output logic                      m_axi_bready_o
   );

   dma_pkt_s unhash_pkt;
   logic     unhash_v;
   logic     unhash_ready;
   dma_pkt_s cmd_pkt;
   logic     cmd_v;
   logic     cmd_yumi;

   dma_addr_unhash unhash
      (.clk_i(clk_i)
      , .arst_n_i(arst_n_i)
      , .dma_pkt_i(dma_pkt_i)
      , .dma_pkt_v_i(dma_pkt_v_i)
      , .dma_pkt_ready_o(dma_pkt_ready_o)
      , .unhash_pkt_o(unhash_pkt)
      , .unhash_v_o(unhash_v)
      , .unhash_ready_i(unhash_ready)
      );

   dma_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo
      (.clk_i(clk_i)
      , .arst_n_i(arst_n_i)
      , .data_i(unhash_pkt)
      , .v_i(unhash_v)
      , .ready_o(unhash_ready)
      , .data_o(cmd_pkt)
      , .v_o(cmd_v)
      , .yumi_i(cmd_yumi)
      );

   // DMA data and AXI ports share names with the engine
   axi_burst_master #(.BURST_LEN(BURST_LEN)) burst
      (.cmd_pkt_i(cmd_pkt)
      , .cmd_v_i(cmd_v)
      , .cmd_yumi_o(cmd_yumi)
      , .*
      );

endmodule

`default_nettype wire

//--- testbench/tb_cache_dma_axi.sv
// Cache DMA to AXI4 bridge testbench

`default_nettype none

module tb_cache_dma_axi
   import dma_pkg::*;
   import axi_pkg::*;
   ();

   localparam int FIFO_DEPTH = 4;
   localparam int BURST_LEN  = 4;
   localparam logic [63:0] FRESH_PATTERN = 64'h5a5a_0000_0000_0000;

   logic clk_i;
   logic arst_n_i;
   dma_pkt_s dma_pkt_i;
   logic dma_pkt_v_i;
   logic dma_pkt_ready_o;
   logic [DATA_WIDTH-1:0] dma_data_i;
   logic dma_data_v_i;
   logic dma_data_ready_o;
   logic [DATA_WIDTH-1:0] dma_data_o;
   logic dma_data_v_o;
   logic dma_data_ready_i;
   logic [ADDR_WIDTH-1:0] m_axi_araddr_o;
   logic [AXI_LEN_WIDTH-1:0] m_axi_arlen_o;
   logic [AXI_SIZE_WIDTH-1:0] m_axi_arsize_o;
   logic [1:0] m_axi_arburst_o;
   logic m_axi_arvalid_o;
   logic m_axi_arready_i;
   logic [DATA_WIDTH-1:0] m_axi_rdata_i;
   logic [1:0] m_axi_rresp_i;
   logic m_axi_rlast_i;
   logic m_axi_rvalid_i;
   logic m_axi_rready_o;
   logic [ADDR_WIDTH-1:0] m_axi_awaddr_o;
   logic [AXI_LEN_WIDTH-1:0] m_axi_awlen_o;
   logic [AXI_SIZE_WIDTH-1:0] m_axi_awsize_o;
   logic [1:0] m_axi_awburst_o;
   logic m_axi_awvalid_o;
   logic m_axi_awready_i;
   logic [DATA_WIDTH-1:0] m_axi_wdata_o;
   logic [DATA_WIDTH/8-1:0] m_axi_wstrb_o;
   logic m_axi_wlast_o;
   logic m_axi_wvalid_o;
   logic m_axi_wready_i;
   logic [1:0] m_axi_bresp_i;
   logic m_axi_bvalid_i;
   logic m_axi_bready_o;

   // Case list and results
   logic        wnr_q[$];
   logic [31:0] addr_q[$];
   logic [63:0] seed_q[$];
   int          case_errs[$];
   int n_cases = 0;
   int cases_done = 0;
   int issue_idx = 0;
   int pass_count = 0;
   int fail_count = 0;
   int misc_errs = 0;

   // AXI memory model state
   logic [63:0] mem [logic [31:0]];
   logic [31:0] rng;
   logic [31:0] rd_addr;
   logic [31:0] wr_addr;
   logic        rd_active;
   logic        wr_active;
   logic        b_pend;
   int          rd_beat;
   int          wr_beat;
   int          rd_case;
   int          wr_case;

   cache_dma_axi_top #(.FIFO_DEPTH(FIFO_DEPTH), .BURST_LEN(BURST_LEN)) DUT (.*);

   always #5 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Bank field XOR low row bits
   function automatic logic [31:0] unhash(input logic [31:0] a);
      return {a[31:11], a[10:8] ^ a[13:11], a[7:0]};
   endfunction

   function automatic logic [63:0] mem_read(input logic [31:0] a);
      if (mem.exists(a))
         return mem[a];
      else
         return {32'h0, a} ^ FRESH_PATTERN;
   endfunction

   // Latest earlier write to the same block wins
   function automatic logic [63:0] expected_beat(input int idx, input int k);
      logic [63:0] val;
      int j;
      val = {32'h0, unhash(addr_q[idx]) + 32'(8 * k)} ^ FRESH_PATTERN;
      for (j = 0; j < idx; j++)
         if (wnr_q[j] && unhash(addr_q[j]) == unhash(addr_q[idx]))
            val = seed_q[j] + 64'(k);
      return val;
   endfunction

   task automatic report_mismatch(input int idx, input string msg);
      $display("MISMATCH @%0t: %s", $time, msg);
      if (idx >= 0)
         case_errs[idx]++;
      else
         misc_errs++;
   endtask

   task automatic finish_case(input int idx);
      $display("case %0d %s %h: %s", idx, wnr_q[idx] ? "W" : "R", addr_q[idx],
               case_errs[idx] == 0 ? "ok" : "FAILED");
      if (case_errs[idx] == 0)
         pass_count++;
      else
         fail_count++;
      cases_done++;
   endtask

   task automatic check_reset_outputs();
      logic [7:0] outs;
      outs = {dma_pkt_ready_o, dma_data_v_o, dma_data_ready_o, m_axi_arvalid_o,
              m_axi_awvalid_o, m_axi_wvalid_o, m_axi_bready_o, m_axi_rready_o};
      if (outs != 8'h00)
         report_mismatch(-1, $sformatf("reset outputs %b, expected all low", outs));
   endtask

   task automatic check_burst(input logic wnr, input logic [31:0] addr,
                              input logic [3:0] len, input logic [2:0] size,
                              input logic [1:0] burst);
      if (issue_idx >= n_cases)
      begin
         $display("Unexpected extra burst at time %0t after every case was issued", $time);
         misc_errs++;
      end
      else
      begin
         if (wnr != wnr_q[issue_idx])
            report_mismatch(issue_idx, $sformatf("case %0d burst direction", issue_idx));
         if (addr != unhash(addr_q[issue_idx]))
            report_mismatch(issue_idx, $sformatf("case %0d address %h expected %h",
                            issue_idx, addr, unhash(addr_q[issue_idx])));
         if (len != 4'(BURST_LEN - 1) || size != AXI_SIZE_BYTES_8 || burst != INCR)
            report_mismatch(issue_idx, $sformatf("case %0d len %0d size %0d burst %0d",
                            issue_idx, len, size, burst));
      end
   endtask

   // Handshakes sampled at the falling edge where the model advances
   always @(negedge clk_i)
   begin
      if (arst_n_i && m_axi_arvalid_o && m_axi_arready_i)
      begin
         check_burst(1'b0, m_axi_araddr_o, m_axi_arlen_o, m_axi_arsize_o, m_axi_arburst_o);
         rd_case = issue_idx;
         rd_addr = m_axi_araddr_o;
         rd_beat = 0;
         rd_active = 1'b1;
         issue_idx++;
      end
      if (arst_n_i && m_axi_awvalid_o && m_axi_awready_i)
      begin
         check_burst(1'b1, m_axi_awaddr_o, m_axi_awlen_o, m_axi_awsize_o, m_axi_awburst_o);
         wr_case = issue_idx;
         wr_addr = m_axi_awaddr_o;
         wr_beat = 0;
         wr_active = 1'b1;
         issue_idx++;
      end
      if (arst_n_i && dma_data_v_o && dma_data_ready_i && !(m_axi_rvalid_i && m_axi_rready_o))
      begin
         $display("DMA fill beat at time %0t without a matching R transfer", $time);
         misc_errs++;
      end
      if (arst_n_i && m_axi_rvalid_i && m_axi_rready_o)
      begin
         if (!dma_data_v_o)
            report_mismatch(rd_case, "R beat taken without dma_data_v_o");
         if (rd_case < n_cases && dma_data_o != expected_beat(rd_case, rd_beat))
            report_mismatch(rd_case, $sformatf("case %0d read beat %0d data %h expected %h",
                            rd_case, rd_beat, dma_data_o, expected_beat(rd_case, rd_beat)));
         rd_beat++;
         if (rd_beat == BURST_LEN)
         begin
            rd_active = 1'b0;
            if (rd_case < n_cases)
               finish_case(rd_case);
         end
      end
      if (arst_n_i && m_axi_wvalid_o && m_axi_wready_i)
      begin
         if (!wr_active || wr_case >= n_cases)
         begin
            $display("W beat at time %0t arrived before its AW handshake", $time);
            misc_errs++;
         end
         else
         begin
            if (m_axi_wdata_o != seed_q[wr_case] + 64'(wr_beat))
               report_mismatch(wr_case, $sformatf("case %0d write beat %0d data %h expected %h",
                               wr_case, wr_beat, m_axi_wdata_o, seed_q[wr_case] + 64'(wr_beat)));
            if (m_axi_wstrb_o != 8'hff || m_axi_wlast_o != (wr_beat == BURST_LEN - 1))
               report_mismatch(wr_case, $sformatf("case %0d beat %0d wstrb %h wlast %b",
                               wr_case, wr_beat, m_axi_wstrb_o, m_axi_wlast_o));
            mem[wr_addr + 32'(8 * wr_beat)] = m_axi_wdata_o;
            wr_beat++;
            if (wr_beat == BURST_LEN)
            begin
               wr_active = 1'b0;
               b_pend = 1'b1;
            end
         end
      end
      if (arst_n_i && m_axi_bvalid_i && m_axi_bready_o)
      begin
         b_pend = 1'b0;
         finish_case(wr_case);
      end
   end

   // Slave outputs and random readies
   always @(posedge clk_i)
   begin
      #1;
      rng = xorshift32(rng);
      m_axi_arready_i  = rng[1:0] != 2'b00;
      m_axi_awready_i  = rng[3:2] != 2'b00;
      m_axi_wready_i   = rng[5:4] != 2'b00;
      dma_data_ready_i = rng[7:6] != 2'b00;
      m_axi_rvalid_i   = rd_active;
      m_axi_rdata_i    = mem_read(rd_addr + 32'(8 * rd_beat));
      m_axi_rlast_i    = rd_active && (rd_beat == BURST_LEN - 1);
      m_axi_bvalid_i   = b_pend;
   end

   task automatic load_cases();
      int fd;
      string line;
      logic [31:0] a;
      logic [63:0] s;
      fd = $fopen("testbench/dma_cases.txt", "r");
      if (fd != 0)
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 2 && (line[0] == "R" || line[0] == "W")
                && $sscanf(line.substr(1, line.len() - 1), "%h %h", a, s) == 2)
            begin
               wnr_q.push_back(line[0] == "W");
               addr_q.push_back(a);
               seed_q.push_back(s);
               case_errs.push_back(0);
            end
         end
         $fclose(fd);
      end
      n_cases = wnr_q.size();
   endtask

   // Back-to-back packets fill the FIFO under slow readies
   task automatic send_packets();
      int i;
      for (i = 0; i < n_cases; i++)
      begin
         dma_pkt_i.write_not_read = wnr_q[i];
         dma_pkt_i.addr.flat = addr_q[i];
         dma_pkt_v_i = 1'b1;
         @(negedge clk_i);
         while (!dma_pkt_ready_o)
            @(negedge clk_i);
         @(posedge clk_i);
         #1;
      end
      dma_pkt_v_i = 1'b0;
   endtask

   task automatic drive_write_data();
      int i;
      int k;
      for (i = 0; i < n_cases; i++)
      begin
         for (k = 0; k < BURST_LEN && wnr_q[i]; k++)
         begin
            dma_data_i = seed_q[i] + 64'(k);
            dma_data_v_i = 1'b1;
            @(negedge clk_i);
            while (!dma_data_ready_o)
               @(negedge clk_i);
            @(posedge clk_i);
            #1;
         end
      end
      dma_data_v_i = 1'b0;
   endtask

   task automatic run_cases();
      int i;
      for (i = 0; i < 3; i++)
      begin
         @(negedge clk_i);
         check_reset_outputs();
      end
      @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      @(negedge clk_i);
      check_reset_outputs();
      $display("reset state: %s", misc_errs == 0 ? "ok" : "FAILED");
      if (misc_errs == 0)
         pass_count++;
      else
         fail_count++;
      @(posedge clk_i);
      #1;
      fork
         send_packets();
         drive_write_data();
      join_none
      wait (cases_done == n_cases);
      // Room for a stray duplicate burst to show up
      repeat (20) @(negedge clk_i);
      $display("%0d tests passed, %0d failed, %0d other errors",
               pass_count, fail_count, misc_errs);
      if (fail_count == 0 && misc_errs == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   endtask

   initial
   begin
      clk_i = 1'b0;
      arst_n_i = 1'b0;
      dma_pkt_i = '0;
      dma_pkt_v_i = 1'b0;
      dma_data_i = '0;
      dma_data_v_i = 1'b0;
      dma_data_ready_i = 1'b0;
      m_axi_arready_i = 1'b0;
      m_axi_rdata_i = '0;
      m_axi_rresp_i = OKAY;
      m_axi_rlast_i = 1'b0;
      m_axi_rvalid_i = 1'b0;
      m_axi_awready_i = 1'b0;
      m_axi_wready_i = 1'b0;
      m_axi_bresp_i = OKAY;
      m_axi_bvalid_i = 1'b0;
      rng = 32'h4ab2c970;
      rd_active = 1'b0;
      wr_active = 1'b0;
      b_pend = 1'b0;
      rd_addr = '0;
      wr_addr = '0;
      rd_beat = 0;
      wr_beat = 0;
      rd_case = 0;
      wr_case = 0;
      load_cases();
      if (n_cases == 0)
      begin
         $display("No cases could be read from testbench/dma_cases.txt");
         $display("ERRORS FOUND");
         $finish;
      end
      else
         run_cases();
   end

   // Watchdog
   initial
   begin
      wait (n_cases > 0);
      repeat (n_cases * 300) @(posedge clk_i);
      $display("Run timed out after %0d cycles with %0d of %0d cases finished",
               n_cases * 300, cases_done, n_cases);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/dma_cases.txt
# Columns: op (R read, W write), hashed DRAM address (hex), write data seed (hex)
# Read lines carry a zero seed
R 00000000 0000000000000000
W 00000000 1111000000000000
R 00000000 0000000000000000
W 00003920 2222000000000010
W 0000fa40 33330000000000a0
R 00003920 0000000000000000
R 0000fa40 0000000000000000
R 12345660 0000000000000000
W 12345660 4444000000000000
R 12345660 0000000000000000
R 7fff8fe0 0000000000000000
W 0abcd380 5555000000000f00
W 0abcd380 6666000000000000
R 0abcd380 0000000000000000
R 00001800 0000000000000000
W 00001800 7777000000000001
W 00002900 8888000000000002
R 00002900 0000000000000000
R 00001800 0000000000000000
R fedcb7a0 0000000000000000
W fedcb7a0 9999000000000003
R fedcb7a0 0000000000000000
W 3c3c4c80 aaaa000000000004
R 3c3c4c80 0000000000000000

//--- Makefile
SRCS := $(shell grep -v '^+' sources.f)

obj_dir/Vtb_cache_dma_axi: sources.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_cache_dma_axi -f sources.f

run: obj_dir/Vtb_cache_dma_axi testbench/dma_cases.txt
	./obj_dir/Vtb_cache_dma_axi | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- sources.f
rtl/axi_pkg.sv
rtl/dma_pkg.sv
rtl/dma_addr_unhash.sv
rtl/dma_cmd_fifo.sv
rtl/axi_burst_master.sv
rtl/cache_dma_axi_top.sv
testbench/tb_cache_dma_axi.sv
